//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_issue_sched
RTL_TOP   ?= issue_sched
FILELIST  ?= issue_sched.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out=$$($(OBJ_DIR)/V$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- issue_sched.f
+incdir+include
rtl/rob_pkg.sv
rtl/sched_pkg.sv
rtl/sched_window.sv
rtl/sched_slot_eval.sv
rtl/sched_select.sv
rtl/issue_sched.sv
testbench/tb_issue_sched.sv

//--- rtl/issue_sched.sv
// ================================================
// issue scheduler top level for two ALUs, one AGEN and one FCU
// idle levels are sampled every cycle and there is no handshake
// ================================================

`timescale 1ns/1ps

module issue_sched
	import rob_pkg::*, sched_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  rob_ndx_t                     head_i,
	input  rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input  rob_mask_t                    stomp_i,
	input  unit_idle_t                   idle_i,
	output issue_bundle_t                issue_o
);

	slot_view_t [WINDOW_SIZE-1:0] slots;
	slot_req_t  [WINDOW_SIZE-1:0] reqs;
	rob_ndx_t   [WINDOW_SIZE-1:0] slot_ndx;
	rob_mask_t                    recent_mask;

	sched_window u_window (
		.head_i        (head_i),
		.rob_i         (rob_i),
		.stomp_i       (stomp_i),
		.recent_mask_i (recent_mask),
		.slots_o       (slots)
	);

	// one evaluator per window position
	for (genvar w = 0; w < WINDOW_SIZE; w++) begin : g_eval
		sched_slot_eval u_eval (
			.slot_i (slots[w]),
			.req_o  (reqs[w])
		);
		assign slot_ndx[w] = slots[w].ndx;
	end

	sched_select u_select (
		.clk           (clk),
		.rst           (rst),
		.idle_i        (idle_i),
		.slot_ndx_i    (slot_ndx),
		.req_i         (reqs),
		.issue_o       (issue_o),
		.recent_mask_o (recent_mask)
	);

endmodule

//--- rtl/rob_pkg.sv
// ================================================
// reorder buffer sizes and entry layout as the issue scheduler sees it
// readiness comes precomputed in could_issue
// ================================================

package rob_pkg;

	// ================================================
	// sizes
	// ================================================

	localparam int ROB_ENTRIES = 16;
	localparam int ROB_NDX_W = $clog2(ROB_ENTRIES);

	// index of one ROB entry that wraps modulo ROB_ENTRIES
	typedef logic [ROB_NDX_W-1:0] rob_ndx_t;

	// one bit per ROB entry indexed by rob_ndx_t
	typedef logic [ROB_ENTRIES-1:0] rob_mask_t;

	// ================================================
	// entry contents
	// ================================================

	// unit class an entry needs
	typedef enum logic [1:0] {
		op_alu = 2'd0,
		op_mem = 2'd1,
		op_fc  = 2'd2
	} op_class_e;

	// the rename stage works out could_issue from its operand valid bits
	typedef struct packed {
		logic      v;
		logic      could_issue;
		logic      done;
		logic      out;
		op_class_e opc;
		logic      alu0_only;
	} rob_entry_t;

endpackage

//--- rtl/sched_pkg.sv
// ================================================
// issue window, per-slot request and grant bundle types
// grants carry a ROB index and no operand payload
// ================================================

package sched_pkg;
	import rob_pkg::*;

	// ================================================
	// window
	// ================================================

	// number of entries examined from the head each cycle
	localparam int WINDOW_SIZE = 8;
	localparam int WIN_NDX_W = $clog2(WINDOW_SIZE);

	// position in the window where zero is the head and the oldest
	typedef logic [WIN_NDX_W-1:0] win_ndx_t;

	// one ROB entry in window order plus its ordering context
	typedef struct packed {
		rob_ndx_t   ndx;
		rob_entry_t entry;
		logic       older_mem_pending;
		logic       older_fc_pending;
		logic       recent_issue;
	} slot_view_t;

	// units a slot may request this cycle
	typedef struct packed {
		logic alu;
		logic alu1_ok;
		logic mem;
		logic fc;
	} slot_req_t;

	// ================================================
	// functional units
	// ================================================

	// idle levels that are high when the unit can take a new op
	typedef struct packed {
		logic alu0;
		logic alu1;
		logic agen;
		logic fcu;
	} unit_idle_t;

	// ndx reads as zero when v is low
	typedef struct packed {
		logic     v;
		rob_ndx_t ndx;
	} unit_grant_t;

	typedef struct packed {
		unit_grant_t alu0;
		unit_grant_t alu1;
		unit_grant_t agen;
		unit_grant_t fcu;
	} issue_bundle_t;

endpackage

//--- rtl/sched_select.sv
// ================================================
// one grant per unit appears one edge after the requests
// an entry is held off for two edges after its grant
// ================================================

`timescale 1ns/1ps

module sched_select
	import rob_pkg::*, sched_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  unit_idle_t                    idle_i,
	input  rob_ndx_t  [WINDOW_SIZE-1:0]   slot_ndx_i,
	input  slot_req_t [WINDOW_SIZE-1:0]   req_i,
	output issue_bundle_t                 issue_o,
	output rob_mask_t                     recent_mask_o
);

	logic          alu0_hit;
	logic          alu1_hit;
	logic          agen_hit;
	logic          fcu_hit;
	win_ndx_t      alu0_pos;
	win_ndx_t      alu1_pos;
	win_ndx_t      agen_pos;
	win_ndx_t      fcu_pos;
	issue_bundle_t next_issue;
	rob_mask_t     grant_mask;
	rob_mask_t     recent_q1;
	rob_mask_t     recent_q2;
	logic          last_fcu_q;

	function automatic unit_grant_t make_grant(input logic hit, input rob_ndx_t ndx);
		unit_grant_t g;
		g.v = hit;
		g.ndx = hit ? ndx : '0;
		return g;
	endfunction

	function automatic rob_mask_t grant_bit(input unit_grant_t g);
		return g.v ? (rob_mask_t'(1) << g.ndx) : '0;
	endfunction

	// ================================================
	// oldest first selection
	// ================================================

	always_comb begin
		alu0_hit = 1'b0;
		alu1_hit = 1'b0;
		agen_hit = 1'b0;
		fcu_hit = 1'b0;
		alu0_pos = '0;
		alu1_pos = '0;
		agen_pos = '0;
		fcu_pos = '0;
		for (int s = 0; s < WINDOW_SIZE; s++) begin
			// ALU1 only looks at a slot that ALU0 passed over
			if (req_i[s].alu && idle_i.alu0 && !alu0_hit) begin
				alu0_hit = 1'b1;
				alu0_pos = win_ndx_t'(s);
			end
			else if (req_i[s].alu1_ok && idle_i.alu1 && !alu1_hit) begin
				alu1_hit = 1'b1;
				alu1_pos = win_ndx_t'(s);
			end
			if (req_i[s].mem && idle_i.agen && !agen_hit) begin
				agen_hit = 1'b1;
				agen_pos = win_ndx_t'(s);
			end
			// the FCU takes at most one op every other cycle
			if (req_i[s].fc && idle_i.fcu && !last_fcu_q && !fcu_hit) begin
				fcu_hit = 1'b1;
				fcu_pos = win_ndx_t'(s);
			end
		end
	end

	always_comb begin
		next_issue.alu0 = make_grant(alu0_hit, slot_ndx_i[alu0_pos]);
		next_issue.alu1 = make_grant(alu1_hit, slot_ndx_i[alu1_pos]);
		next_issue.agen = make_grant(agen_hit, slot_ndx_i[agen_pos]);
		next_issue.fcu = make_grant(fcu_hit, slot_ndx_i[fcu_pos]);
	end

	// ROB entries picked this cycle by any unit
	assign grant_mask = grant_bit(next_issue.alu0)
		| grant_bit(next_issue.alu1)
		| grant_bit(next_issue.agen)
		| grant_bit(next_issue.fcu);

	// ================================================
	// registered grants and issue history
	// ================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			issue_o <= '0;
			recent_q1 <= '0;
			recent_q2 <= '0;
			last_fcu_q <= 1'b0;
		end
		else begin
			issue_o <= next_issue;
			recent_q1 <= grant_mask;
			recent_q2 <= recent_q1;
			last_fcu_q <= next_issue.fcu.v;
		end
	end

	// q1 blocks the edge after the grant and q2 the one after that
	assign recent_mask_o = recent_q1 | recent_q2;

endmodule

//--- rtl/sched_slot_eval.sv
// ================================================
// combinational evaluation of one window slot
// unit idle levels are applied later in the selector
// ================================================

`timescale 1ns/1ps

module sched_slot_eval
	import rob_pkg::*, sched_pkg::*;
(
	input  slot_view_t slot_i,
	output slot_req_t  req_o
);

	logic eligible;
	logic is_alu;
	logic is_mem;
	logic is_fc;

	// ================================================
	// eligibility
	// ================================================

	// the entry must be live and ready, and neither running nor finished
	// an entry granted in the last two cycles waits so that it is not issued twice
	assign eligible = slot_i.entry.v
		& slot_i.entry.could_issue
		& ~slot_i.entry.done
		& ~slot_i.entry.out
		& ~slot_i.recent_issue;

	assign is_alu = eligible & (slot_i.entry.opc == op_alu);
	assign is_mem = eligible & (slot_i.entry.opc == op_mem);
	assign is_fc = eligible & (slot_i.entry.opc == op_fc);

	// ================================================
	// per unit requests
	// ================================================

	assign req_o.alu = is_alu;

	// some ALU ops exist only on ALU0
	assign req_o.alu1_ok = is_alu & ~slot_i.entry.alu0_only;

	// memory ops go to the address generator in program order
	assign req_o.mem = is_mem & ~slot_i.older_mem_pending;

	// flow control also stays in order
	assign req_o.fc = is_fc & ~slot_i.older_fc_pending;

endmodule

//--- rtl/sched_window.sv
// ================================================
// the window is combinational and must not be larger than the ROB
// stomped entries count as invalid for the ordering flags too
// ================================================

`timescale 1ns/1ps

module sched_window
	import rob_pkg::*, sched_pkg::*;
(
	input  rob_ndx_t                         head_i,
	input  rob_entry_t [ROB_ENTRIES-1:0]     rob_i,
	input  rob_mask_t                        stomp_i,
	input  rob_mask_t                        recent_mask_i,
	output slot_view_t [WINDOW_SIZE-1:0]     slots_o
);

	rob_ndx_t   pos_ndx;
	rob_entry_t ent;
	logic       mem_seen;
	logic       fc_seen;

	// ================================================
	// rotate from the head and build prefix flags
	// ================================================

	// walk the window in program order and carry the ordering state along
	always_comb begin
		mem_seen = 1'b0;
		fc_seen = 1'b0;
		pos_ndx = head_i;
		ent = rob_i[head_i];
		for (int w = 0; w < WINDOW_SIZE; w++) begin
			// the 4 bit add wraps the index around the end of the ROB
			pos_ndx = head_i + rob_ndx_t'(w);
			ent = rob_i[pos_ndx];
			ent.v = ent.v & ~stomp_i[pos_ndx];

			slots_o[w].ndx = pos_ndx;
			slots_o[w].entry = ent;
			slots_o[w].older_mem_pending = mem_seen;
			slots_o[w].older_fc_pending = fc_seen;
			slots_o[w].recent_issue = recent_mask_i[pos_ndx];

			// a valid op of a class that has not finished holds back younger ops of that class
			mem_seen = mem_seen | (ent.v & ~ent.done & (ent.opc == op_mem));
			fc_seen = fc_seen | (ent.v & ~ent.done & (ent.opc == op_fc));
		end
	end

endmodule

//--- include/tb_checks.svh
// ================================================
// include inside a module that imports sched_pkg
// the first mismatch ends the simulation
// ================================================

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ================================================
// reporting
// ================================================

task automatic report_mismatch(input string unit, input string what);
	$display("ERR %0t %s %s", $time, unit, what);
endtask

task automatic fail_run(input string why);
	$display("TEST FAILED");
	$fatal(1, "%s", why);
endtask

// ================================================
// compares
// ================================================

// x or z on the DUT side also counts as a mismatch
task automatic check_grant(input string unit, input unit_grant_t got, input unit_grant_t exp);
	if (got !== exp) begin
		report_mismatch(unit, $sformatf("got v=%0b ndx=%0d, expected v=%0b ndx=%0d",
			got.v, got.ndx, exp.v, exp.ndx));
		fail_run("grant does not match the expected value");
	end
endtask

task automatic check_bundle(input issue_bundle_t got, input issue_bundle_t exp);
	check_grant("alu0", got.alu0, exp.alu0);
	check_grant("alu1", got.alu1, exp.alu1);
	check_grant("agen", got.agen, exp.agen);
	check_grant("fcu", got.fcu, exp.fcu);
endtask

`endif

//--- testbench/tb_issue_sched.sv
// ==================================================
// each table row runs after three empty cycles that drain the issue history
// inputs change and issue_o is read half a nanosecond after the falling edge
// ==================================================

`timescale 1ns/1ps

module tb_issue_sched
	import rob_pkg::*, sched_pkg::*;
();

	`include "tb_checks.svh"

	localparam int NUM_ROWS = 10;
	localparam int EDGE_POLLS = 20;
	localparam unit_grant_t NONE = '0;
	localparam unit_idle_t ALL_IDLE = 4'b1111;

	// field order is v, could_issue, done, out, opc, alu0_only
	localparam rob_entry_t ALU_RDY = '{1'b1, 1'b1, 1'b0, 1'b0, op_alu, 1'b0};
	localparam rob_entry_t ALU0_RDY = '{1'b1, 1'b1, 1'b0, 1'b0, op_alu, 1'b1};
	localparam rob_entry_t MEM_RDY = '{1'b1, 1'b1, 1'b0, 1'b0, op_mem, 1'b0};
	localparam rob_entry_t MEM_WAIT = '{1'b1, 1'b0, 1'b0, 1'b0, op_mem, 1'b0};
	localparam rob_entry_t MEM_DONE = '{1'b1, 1'b1, 1'b1, 1'b0, op_mem, 1'b0};
	localparam rob_entry_t FC_RDY = '{1'b1, 1'b1, 1'b0, 1'b0, op_fc, 1'b0};

	// exp[n] is the bundle expected after the n-th application of the row
	// entries in done_2nd have finished by the second application
	typedef struct packed {
		rob_ndx_t                     head;
		rob_entry_t [ROB_ENTRIES-1:0] rob;
		rob_mask_t                    stomp;
		rob_mask_t                    done_2nd;
		unit_idle_t                   idle;
		logic [1:0]                   reps;
		issue_bundle_t [1:0]          exp;
	} row_t;

	logic                         clk;
	logic                         rst;
	rob_ndx_t                     head;
	rob_entry_t [ROB_ENTRIES-1:0] rob;
	rob_mask_t                    stomp;
	unit_idle_t                   idle;
	issue_bundle_t                issue;
	row_t                         rows [NUM_ROWS];

	issue_sched UUT (
		.clk     (clk),
		.rst     (rst),
		.head_i  (head),
		.rob_i   (rob),
		.stomp_i (stomp),
		.idle_i  (idle),
		.issue_o (issue)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	function automatic unit_grant_t grant_to(input rob_ndx_t ndx);
		unit_grant_t g;
		g.v = 1'b1;
		g.ndx = ndx;
		return g;
	endfunction

	task automatic set_row(input int k, input rob_ndx_t hd, input rob_mask_t stm,
			input unit_idle_t idl, input logic [1:0] reps,
			input issue_bundle_t exp0, input issue_bundle_t exp1);
		rows[k].head = hd;
		rows[k].rob = '0;
		rows[k].stomp = stm;
		rows[k].done_2nd = '0;
		rows[k].idle = idl;
		rows[k].reps = reps;
		rows[k].exp[0] = exp0;
		rows[k].exp[1] = exp1;
	endtask

	task automatic put_entry(input int k, input rob_ndx_t ndx, input rob_entry_t e);
		rows[k].rob[ndx] = e;
	endtask

	// ==================================================
	// stimulus table
	// ==================================================

	task automatic build_table();
		// the head sits near the top so the window wraps round to entry 0
		set_row(0, 4'd14, 16'h0, ALL_IDLE, 2'd1,
			{grant_to(4'd15), grant_to(4'd0), NONE, NONE}, '0);
		put_entry(0, 4'd15, ALU_RDY);
		put_entry(0, 4'd0, ALU_RDY);
		set_row(1, 4'd3, 16'h0, ALL_IDLE, 2'd1,
			{grant_to(4'd3), grant_to(4'd5), NONE, NONE}, '0);
		put_entry(1, 4'd3, ALU0_RDY);
		put_entry(1, 4'd5, ALU_RDY);
		set_row(2, 4'd3, 16'h0, 4'b0111, 2'd1, {NONE, grant_to(4'd5), NONE, NONE}, '0);
		put_entry(2, 4'd3, ALU0_RDY);
		put_entry(2, 4'd5, ALU_RDY);
		// the older memory op is still pending so the younger one waits
		set_row(3, 4'd0, 16'h0, ALL_IDLE, 2'd1, '0, '0);
		put_entry(3, 4'd1, MEM_WAIT);
		put_entry(3, 4'd2, MEM_RDY);
		set_row(4, 4'd0, 16'h0, ALL_IDLE, 2'd1, {NONE, NONE, grant_to(4'd2), NONE}, '0);
		put_entry(4, 4'd1, MEM_DONE);
		put_entry(4, 4'd2, MEM_RDY);
		// entries 4 and 6 are stomped
		set_row(5, 4'd0, 16'h0050, ALL_IDLE, 2'd1,
			{grant_to(4'd5), NONE, grant_to(4'd7), NONE}, '0);
		put_entry(5, 4'd4, ALU_RDY);
		put_entry(5, 4'd5, ALU_RDY);
		put_entry(5, 4'd6, MEM_RDY);
		put_entry(5, 4'd7, MEM_RDY);
		// entry 9 finishes before the second cycle and frees entry 11
		// which still waits because the FCU was granted at the previous edge
		set_row(6, 4'd8, 16'h0, ALL_IDLE, 2'd2, {NONE, NONE, NONE, grant_to(4'd9)}, '0);
		put_entry(6, 4'd9, FC_RDY);
		put_entry(6, 4'd11, FC_RDY);
		rows[6].done_2nd = 16'h0200;
		set_row(7, 4'd2, 16'h0, ALL_IDLE, 2'd2, {grant_to(4'd4), NONE, NONE, NONE}, '0);
		put_entry(7, 4'd4, ALU_RDY);
		set_row(8, 4'd2, 16'h0, 4'b1101, 2'd1,
			{grant_to(4'd3), NONE, NONE, grant_to(4'd4)}, '0);
		put_entry(8, 4'd2, MEM_RDY);
		put_entry(8, 4'd3, ALU_RDY);
		put_entry(8, 4'd4, FC_RDY);
		set_row(9, 4'd12, 16'h0, 4'b1010, 2'd1, {grant_to(4'd12), NONE, NONE, NONE}, '0);
		put_entry(9, 4'd12, ALU_RDY);
		put_entry(9, 4'd13, ALU_RDY);
		put_entry(9, 4'd14, FC_RDY);
	endtask

	// ==================================================
	// driving and waiting
	// ==================================================

	task automatic drive_blank();
		head = '0;
		rob = '0;
		stomp = '0;
		idle = ALL_IDLE;
	endtask

	task automatic drive_row(input row_t r, input int rep);
		rob_entry_t [ROB_ENTRIES-1:0] ents;
		int e;
		ents = r.rob;
		if (rep > 0) begin
			for (e = 0; e < ROB_ENTRIES; e++) begin
				ents[e].done = ents[e].done | r.done_2nd[e];
			end
		end
		head = r.head;
		rob = ents;
		stomp = r.stomp;
		idle = r.idle;
	endtask

	// polls sit half a nanosecond off the clock grid and never share a time with an edge
	task automatic wait_edge(input logic level);
		int n;
		n = 0;
		while (clk === level && n < EDGE_POLLS) begin
			#1;
			n++;
		end
		while (clk !== level && n < EDGE_POLLS) begin
			#1;
			n++;
		end
		if (clk !== level) begin
			fail_run("the clock edge did not arrive in time");
		end
	endtask

	initial begin
		int k;
		int rep;
		rst = 1'b1;
		drive_blank();
		build_table();
		// move off the clock grid once so that every later poll falls between edges
		#0.5;
		for (k = 0; k < 4; k++) begin
			wait_edge(1'b1);
			check_bundle(issue, '0);
		end
		wait_edge(1'b0);
		rst = 1'b0;
		for (k = 0; k < NUM_ROWS; k++) begin
			drive_blank();
			for (rep = 0; rep < 3; rep++) begin
				wait_edge(1'b1);
				wait_edge(1'b0);
			end
			check_bundle(issue, '0);
			for (rep = 0; rep < int'(rows[k].reps); rep++) begin
				drive_row(rows[k], rep);
				wait_edge(1'b1);
				wait_edge(1'b0);
				check_bundle(issue, rows[k].exp[rep]);
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule
